// ==== paCore.f ====
common/paCoreCfgPkg.sv
common/paIsaPkg.sv
common/paLaneIf.sv
fetch/bundleFetch.sv
src/laneDecoder.sv
src/regFile.sv
src/arithUnit.sv
src/paCore.sv
tb/paCoreTb.sv

// ==== run.sh ====
#!/bin/sh

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module paCoreTb -f paCore.f -o paCoreSim; then
	echo "verilator build failed"
	exit 1
fi

if ! ./obj_dir/paCoreSim; then
	echo "simulation reported a failure"
	exit 1
fi

exit 0

// ==== tb/paCoreTb.sv ====
`default_nettype none

module paCoreTb;

	localparam int bundleDepth = paCoreCfgPkg::defaultBundleDepth;
	localparam int period = 40;
	localparam int driveDelay = 2;
	// address byte, eight data bytes and one commit per bundle
	localparam int loadCycles = bundleDepth * 10;
	// nop bundles at the end, drained before the pc wraps
	localparam int tailNops = 5;

	logic clock = 1'b0;
	logic reset;
	logic shiftEn;
	paCoreCfgPkg::byteT shiftData;
	logic isAddress;
	logic shiftOutEn;
	paCoreCfgPkg::pcT pc;
	logic wbValidA;
	logic wbValidB;
	paCoreCfgPkg::regAddrT wbAddrA;
	paCoreCfgPkg::regAddrT wbAddrB;
	paCoreCfgPkg::dataT wbDataA;
	paCoreCfgPkg::dataT wbDataB;

	logic [31:0] rngState = 32'h3f3a;
	logic [63:0] progMem [bundleDepth];
	// model register file and last writing bundle per register
	paCoreCfgPkg::dataT model [32];
	int lastWrite [32];
	// expected writebacks, {addr, data}
	logic [20:0] expA [$];
	logic [20:0] expB [$];
	logic running = 1'b0;

	// pc model state, inputs seen at the previous rising edge
	logic sampledReset = 1'b0;
	logic sampledShift = 1'b0;
	logic pcKnown = 1'b0;
	int pcModel = 0;

	paCore #(.bundleDepth(bundleDepth)) dut (
		.clock_i(clock), .reset_i(reset),
		.shiftEn_i(shiftEn), .shiftData_i(shiftData),
		.isAddress_i(isAddress), .shiftOutEn_i(shiftOutEn),
		.pc_o(pc),
		.wbValidA_o(wbValidA), .wbAddrA_o(wbAddrA), .wbDataA_o(wbDataA),
		.wbValidB_o(wbValidB), .wbAddrB_o(wbAddrB), .wbDataB_o(wbDataB)
	);

	always #(period / 2) clock = ~clock;

	////////////////////////////////////////////////////////////
	// random source and reference model
	////////////////////////////////////////////////////////////
	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] nextRand();
		rngState = xorshift(rngState);
		return rngState;
	endfunction

	// 16-bit wrapping result of one lane
	function automatic paCoreCfgPkg::dataT refResult(input logic [6:0] op,
		input paCoreCfgPkg::dataT prim, input paCoreCfgPkg::dataT sec);
		case (op)
			paIsaPkg::add: return prim + sec;
			paIsaPkg::sub: return prim - sec;
			paIsaPkg::andOp: return prim & sec;
			paIsaPkg::orOp: return prim | sec;
			paIsaPkg::xorOp: return prim ^ sec;
			paIsaPkg::mov: return sec;
			default: return prim;
		endcase
	endfunction

	// nop and unknown codes write nothing
	function automatic bit refWrites(input logic [6:0] op);
		return (op >= 7'(paIsaPkg::add)) && (op <= 7'(paIsaPkg::mov));
	endfunction

	function automatic logic [31:0] makeInstr(input int idx);
		logic [31:0] r;
		logic [31:0] s;
		logic [6:0] op;
		logic fmt;
		logic [15:0] sec;
		r = nextRand();
		s = nextRand();
		// mostly defined opcodes, some unknown ones
		if (r[3:0] < 4'd13)
			op = 7'(r[3:0] % 4'd7);
		else
			op = 7'd7 + (r[30:24] % 7'd121);
		fmt = r[4];
		// first bundles seed registers with immediates
		if (idx < 4)
		begin
			op = paIsaPkg::mov;
			fmt = 1'b1;
		end
		// register index in the low bits, junk above it
		sec = fmt ? s[15:0] : {s[15:5], 2'b00, s[2:0]};
		return {op, fmt, r[10:8], 2'b00, r[7:5], sec};
	endfunction

	// first slot where every source of instr is written back
	function automatic int readyAt(input logic [31:0] instr);
		int ready;
		ready = lastWrite[instr[20:16]] + 3;
		if (!instr[24] && (lastWrite[instr[4:0]] + 3 > ready))
			ready = lastWrite[instr[4:0]] + 3;
		return ready;
	endfunction

	task automatic modelBundle(input logic [31:0] instrA, input logic [31:0] instrB);
		paCoreCfgPkg::dataT secA;
		paCoreCfgPkg::dataT secB;
		paCoreCfgPkg::dataT resA;
		paCoreCfgPkg::dataT resB;
		secA = instrA[24] ? instrA[15:0] : model[instrA[4:0]];
		secB = instrB[24] ? instrB[15:0] : model[instrB[4:0]];
		// both lanes read the state from before the bundle
		resA = refResult(instrA[31:25], model[instrA[20:16]], secA);
		resB = refResult(instrB[31:25], model[instrB[20:16]], secB);
		if (refWrites(instrA[31:25]))
		begin
			expA.push_back({instrA[20:16], resA});
			model[instrA[20:16]] = resA;
		end
		// lane B last, so it wins a shared register
		if (refWrites(instrB[31:25]))
		begin
			expB.push_back({instrB[20:16], resB});
			model[instrB[20:16]] = resB;
		end
	endtask

	task automatic buildProgram();
		int slot;
		int needed;
		logic [31:0] instrA;
		logic [31:0] instrB;
		slot = 0;
		for (int r = 0; r < 32; r++)
		begin
			model[r] = '0;
			lastWrite[r] = -3;
		end
		while (slot < bundleDepth - tailNops)
		begin
			instrA = makeInstr(slot);
			instrB = makeInstr(slot);
			// now and then both lanes on one register
			if (nextRand() % 4 == 0)
				instrB[20:16] = instrA[20:16];
			needed = readyAt(instrA);
			if (readyAt(instrB) > needed)
				needed = readyAt(instrB);
			// nop bundles until the sources are ready
			while ((slot < needed) && (slot < bundleDepth - tailNops))
			begin
				progMem[slot] = '0;
				slot++;
			end
			if (slot < bundleDepth - tailNops)
			begin
				progMem[slot] = {instrA, instrB};
				modelBundle(instrA, instrB);
				if (refWrites(instrA[31:25]))
					lastWrite[instrA[20:16]] = slot;
				if (refWrites(instrB[31:25]))
					lastWrite[instrB[20:16]] = slot;
				slot++;
			end
		end
		while (slot < bundleDepth)
		begin
			progMem[slot] = '0;
			slot++;
		end
	endtask

	////////////////////////////////////////////////////////////
	// loader driver
	////////////////////////////////////////////////////////////
	// one loader cycle, held until just after the next rising edge
	task automatic driveLoad(input logic en, input logic isAddr, input logic outEn,
		input paCoreCfgPkg::byteT data);
		shiftEn = en;
		isAddress = isAddr;
		shiftOutEn = outEn;
		shiftData = data;
		@(posedge clock);
		#driveDelay;
	endtask

	task automatic loadProgram();
		for (int i = 0; i < bundleDepth; i++)
		begin
			driveLoad(1'b1, 1'b1, 1'b0, 8'(i));
			// most significant byte first
			for (int b = 7; b >= 0; b--)
				driveLoad(1'b1, 1'b0, 1'b0, progMem[i][b*8 +: 8]);
			driveLoad(1'b1, 1'b0, 1'b1, 8'h00);
		end
	endtask

	////////////////////////////////////////////////////////////
	// checkers
	////////////////////////////////////////////////////////////
	task automatic checkWb(input string lane, input logic [20:0] expected,
		input paCoreCfgPkg::regAddrT addr, input paCoreCfgPkg::dataT data);
		assert ((addr == expected[20:16]) && (data == expected[15:0]))
		else
		begin
			$display("Fail at %0t: lane %s wrote r%0d = %h, expected r%0d = %h", $time, lane,
				addr, data, expected[20:16], expected[15:0]);
			$display("Test failed");
			$fatal(1, "writeback mismatch");
		end
	endtask

	task automatic checkPending(input string lane, input int pending);
		assert (pending > 0)
		else
		begin
			$display("lane %s wrote back at %0t with no writeback expected", lane, $time);
			$display("Test failed");
			$fatal(1, "unexpected writeback");
		end
	endtask

	// writebacks sampled mid-cycle
	always @(negedge clock)
	begin
		if (!running)
		begin
			assert ((wbValidA == 1'b0) && (wbValidB == 1'b0))
			else
			begin
				$display("a writeback valid rose during reset or loading at %0t", $time);
				$display("Test failed");
				$fatal(1, "writeback while idle");
			end
		end
		else
		begin
			if (wbValidA)
			begin
				checkPending("A", expA.size());
				checkWb("A", expA.pop_front(), wbAddrA, wbDataA);
			end
			if (wbValidB)
			begin
				checkPending("B", expB.size());
				checkWb("B", expB.pop_front(), wbAddrB, wbDataB);
			end
		end
	end

	// pc holds while loading, else counts and wraps
	always @(negedge clock)
	begin
		if (sampledReset)
		begin
			pcModel = 0;
			pcKnown = 1'b1;
		end
		else if (pcKnown && !sampledShift)
			pcModel = (pcModel == bundleDepth - 1) ? 0 : pcModel + 1;
		sampledReset = reset;
		sampledShift = shiftEn;
		if (pcKnown)
		begin
			assert (pc == 16'(pcModel))
			else
			begin
				$display("Fail at %0t: pc_o is %0d, expected %0d", $time, pc, pcModel);
				$display("Test failed");
				$fatal(1, "pc mismatch");
			end
		end
	end

	initial
	begin
		#((bundleDepth + loadCycles + 20) * period);
		$display("watchdog expired before the program finished running");
		$display("Test failed");
		$fatal(1, "timeout");
	end

	////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////
	initial
	begin
		reset = 1'b1;
		shiftEn = 1'b0;
		shiftData = '0;
		isAddress = 1'b0;
		shiftOutEn = 1'b0;
		buildProgram();
		repeat (10) @(posedge clock);
		#driveDelay;
		reset = 1'b0;
		loadProgram();
		// short reset so the pc restarts at 0
		shiftEn = 1'b0;
		shiftOutEn = 1'b0;
		reset = 1'b1;
		repeat (2) @(posedge clock);
		#driveDelay;
		reset = 1'b0;
		running = 1'b1;
		// run to the last bundle, real writebacks are done by then
		while (pc != 16'(bundleDepth - 1))
			@(negedge clock);
		@(posedge clock);
		#driveDelay;
		if ((expA.size() == 0) && (expB.size() == 0))
		begin
			$display("Test completed successfully");
			$finish;
		end
		else
		begin
			$display("writebacks missing: %0d on lane A, %0d on lane B", expA.size(),
				expB.size());
			$display("Test failed");
			$fatal(1, "missing writebacks");
		end
	end

endmodule

`default_nettype wire

// ==== src/paCore.sv ====
`default_nettype none

module paCore #(
	parameter int bundleDepth = paCoreCfgPkg::defaultBundleDepth
) (
	input wire clock_i,
	input wire reset_i,

	// loader
	input wire shiftEn_i,
	input paCoreCfgPkg::byteT shiftData_i,
	input wire isAddress_i,
	input wire shiftOutEn_i,

	// observation
	output paCoreCfgPkg::pcT pc_o,
	output logic wbValidA_o,
	output paCoreCfgPkg::regAddrT wbAddrA_o,
	output paCoreCfgPkg::dataT wbDataA_o,
	output logic wbValidB_o,
	output paCoreCfgPkg::regAddrT wbAddrB_o,
	output paCoreCfgPkg::dataT wbDataB_o
);

	paCoreCfgPkg::bundleT bundle;
	logic bundleValid;

	decodedOpIf opA ();
	decodedOpIf opB ();
	issueOpIf issueA ();
	issueOpIf issueB ();

	////////////////////////////////////////////////////////////
	// fetch
	////////////////////////////////////////////////////////////
	bundleFetch #(.bundleDepth(bundleDepth)) fetch (
		.clock_i(clock_i), .reset_i(reset_i),
		.shiftEn_i(shiftEn_i), .shiftData_i(shiftData_i),
		.isAddress_i(isAddress_i), .shiftOutEn_i(shiftOutEn_i),
		.pc_o(pc_o), .bundle_o(bundle), .bundleValid_o(bundleValid)
	);

	// lane A upper half, lane B lower half
	laneDecoder decodeA (.clock_i(clock_i), .reset_i(reset_i),
		.instr_i(bundle[63:32]), .instrValid_i(bundleValid), .op_o(opA));
	laneDecoder decodeB (.clock_i(clock_i), .reset_i(reset_i),
		.instr_i(bundle[31:0]), .instrValid_i(bundleValid), .op_o(opB));

	// writebacks loop back from the top outputs
	regFile registers (
		.clock_i(clock_i), .reset_i(reset_i),
		.opA_i(opA), .opB_i(opB), .issueA_o(issueA), .issueB_o(issueB),
		.wbValidA_i(wbValidA_o), .wbAddrA_i(wbAddrA_o), .wbDataA_i(wbDataA_o),
		.wbValidB_i(wbValidB_o), .wbAddrB_i(wbAddrB_o), .wbDataB_i(wbDataB_o)
	);

	arithUnit arithA (.clock_i(clock_i), .reset_i(reset_i), .issue_i(issueA),
		.wbValid_o(wbValidA_o), .wbAddr_o(wbAddrA_o), .wbData_o(wbDataA_o));
	arithUnit arithB (.clock_i(clock_i), .reset_i(reset_i), .issue_i(issueB),
		.wbValid_o(wbValidB_o), .wbAddr_o(wbAddrB_o), .wbData_o(wbDataB_o));

endmodule

`default_nettype wire

// ==== src/arithUnit.sv ====
`default_nettype none

module arithUnit (
	input wire clock_i,
	input wire reset_i,
	issueOpIf.sink issue_i,
	output logic wbValid_o,
	output paCoreCfgPkg::regAddrT wbAddr_o,
	output paCoreCfgPkg::dataT wbData_o
);

	paCoreCfgPkg::dataT result;

	// 16-bit wrapping results
	always_comb
	begin
		case (issue_i.opcode)
			paIsaPkg::add: result = issue_i.primValue + issue_i.secValue;
			paIsaPkg::sub: result = issue_i.primValue - issue_i.secValue;
			paIsaPkg::andOp: result = issue_i.primValue & issue_i.secValue;
			paIsaPkg::orOp: result = issue_i.primValue | issue_i.secValue;
			paIsaPkg::xorOp: result = issue_i.primValue ^ issue_i.secValue;
			paIsaPkg::mov: result = issue_i.secValue;
			// nop and unknown codes never arrive valid from the decoder
			default:
				result = issue_i.primValue;
		endcase
	end

	// every valid issue op writes back
	always_ff @(posedge clock_i)
	begin
		if (reset_i)
			wbValid_o <= 1'b0;
		else
			wbValid_o <= issue_i.valid;
	end

	// result goes back to the primary register
	always_ff @(posedge clock_i)
	begin
		wbAddr_o <= issue_i.primReg;
		wbData_o <= result;
	end

endmodule

`default_nettype wire

// ==== src/regFile.sv ====
`default_nettype none

module regFile (
	input wire clock_i,
	input wire reset_i,
	decodedOpIf.sink opA_i,
	decodedOpIf.sink opB_i,
	issueOpIf.source issueA_o,
	issueOpIf.source issueB_o,
	input wire wbValidA_i,
	input paCoreCfgPkg::regAddrT wbAddrA_i,
	input paCoreCfgPkg::dataT wbDataA_i,
	input wire wbValidB_i,
	input paCoreCfgPkg::regAddrT wbAddrB_i,
	input paCoreCfgPkg::dataT wbDataB_i
);

	paCoreCfgPkg::dataT regs [32];
	paCoreCfgPkg::dataT primA, secA, primB, secB;

	// write-through read, lane B writeback checked first
	function automatic paCoreCfgPkg::dataT readReg(input paCoreCfgPkg::regAddrT addr);
		if (wbValidB_i && (wbAddrB_i == addr))
			return wbDataB_i;
		else if (wbValidA_i && (wbAddrA_i == addr))
			return wbDataA_i;
		else
			return regs[addr];
	endfunction

	// immediate or register content
	function automatic paCoreCfgPkg::dataT readSec(input paIsaPkg::formatT format,
		input paCoreCfgPkg::dataT secOperand);
		if (format == paIsaPkg::regImm)
			return secOperand;
		else
			return readReg(paCoreCfgPkg::regAddrT'(secOperand));
	endfunction

	always_comb
	begin
		primA = readReg(opA_i.primReg);
		secA = readSec(opA_i.format, opA_i.secOperand);
		primB = readReg(opB_i.primReg);
		secB = readSec(opB_i.format, opB_i.secOperand);
	end

	////////////////////////////////////////////////////////////
	// register writes, B after A so B wins on a clash
	////////////////////////////////////////////////////////////
	always_ff @(posedge clock_i)
	begin
		if (reset_i)
		begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end
		else
		begin
			if (wbValidA_i)
				regs[wbAddrA_i] <= wbDataA_i;
			if (wbValidB_i)
				regs[wbAddrB_i] <= wbDataB_i;
		end
	end

	// issue valids
	always_ff @(posedge clock_i)
	begin
		if (reset_i)
		begin
			issueA_o.valid <= 1'b0;
			issueB_o.valid <= 1'b0;
		end
		else
		begin
			issueA_o.valid <= opA_i.valid;
			issueB_o.valid <= opB_i.valid;
		end
	end

	// issue payload
	always_ff @(posedge clock_i)
	begin
		issueA_o.opcode <= opA_i.opcode;
		issueA_o.primReg <= opA_i.primReg;
		issueA_o.primValue <= primA;
		issueA_o.secValue <= secA;
		issueB_o.opcode <= opB_i.opcode;
		issueB_o.primReg <= opB_i.primReg;
		issueB_o.primValue <= primB;
		issueB_o.secValue <= secB;
	end

endmodule

`default_nettype wire

// ==== src/laneDecoder.sv ====
`default_nettype none

module laneDecoder (
	input wire clock_i,
	input wire reset_i,
	input paCoreCfgPkg::instrT instr_i,
	input wire instrValid_i,
	decodedOpIf.source op_o
);

	paIsaPkg::opcodeT opcode;
	logic knownOp;

	// opcode field and whether it does anything
	always_comb
	begin
		opcode = paIsaPkg::opcodeT'(instr_i[paIsaPkg::opcodeHi:paIsaPkg::opcodeLo]);
		case (opcode)
			paIsaPkg::add, paIsaPkg::sub, paIsaPkg::andOp,
			paIsaPkg::orOp, paIsaPkg::xorOp, paIsaPkg::mov:
				knownOp = 1'b1;
			// nop and unused codes
			default:
				knownOp = 1'b0;
		endcase
	end

	// valid control
	always_ff @(posedge clock_i)
	begin
		if (reset_i)
			op_o.valid <= 1'b0;
		else
			op_o.valid <= instrValid_i && knownOp;
	end

	// field registers
	always_ff @(posedge clock_i)
	begin
		op_o.opcode <= opcode;
		op_o.format <= paIsaPkg::formatT'(instr_i[paIsaPkg::formatPos]);
		op_o.primReg <= instr_i[paIsaPkg::primRegHi:paIsaPkg::primRegLo];
		op_o.secOperand <= instr_i[paIsaPkg::secOperandHi:paIsaPkg::secOperandLo];
	end

endmodule

`default_nettype wire

// ==== fetch/bundleFetch.sv ====
`default_nettype none

module bundleFetch #(
	parameter int bundleDepth = paCoreCfgPkg::defaultBundleDepth
) (
	input wire clock_i,
	input wire reset_i,

	// loader side
	input wire shiftEn_i,
	input paCoreCfgPkg::byteT shiftData_i,
	input wire isAddress_i,
	input wire shiftOutEn_i,

	// fetch side
	output paCoreCfgPkg::pcT pc_o,
	output paCoreCfgPkg::bundleT bundle_o,
	output logic bundleValid_o
);

	localparam int idxW = $clog2(bundleDepth);

	// loader state
	paCoreCfgPkg::pcT writeAddr;
	paCoreCfgPkg::bundleT assembly;

	// bundle storage, kept across reset
	paCoreCfgPkg::bundleT bundleMem [bundleDepth];

	////////////////////////////////////////////////////////////
	// byte loader
	////////////////////////////////////////////////////////////
	always_ff @(posedge clock_i)
	begin
		if (shiftEn_i)
		begin
			// address byte, zero-extended
			if (isAddress_i)
				writeAddr <= {8'b0, shiftData_i};
			// data byte in at the bottom, first byte ends up on top
			else
				assembly <= {assembly[55:0], shiftData_i};
			// commit what was assembled so far
			if (shiftOutEn_i && (writeAddr < paCoreCfgPkg::pcT'(bundleDepth)))
				bundleMem[writeAddr[idxW-1:0]] <= assembly;
		end
	end

	////////////////////////////////////////////////////////////
	// program counter and bundle read
	////////////////////////////////////////////////////////////
	always_ff @(posedge clock_i)
	begin
		if (reset_i)
		begin
			pc_o <= '0;
			bundleValid_o <= 1'b0;
		end
		else if (shiftEn_i)
		begin
			// hold while loading
			bundleValid_o <= 1'b0;
		end
		else
		begin
			bundleValid_o <= 1'b1;
			// wrap at the end of memory
			if (pc_o == paCoreCfgPkg::pcT'(bundleDepth - 1))
				pc_o <= '0;
			else
				pc_o <= pc_o + 1'b1;
		end
	end

	// read data, one cycle behind the pc
	always_ff @(posedge clock_i)
	begin
		bundle_o <= bundleMem[pc_o[idxW-1:0]];
	end

endmodule

`default_nettype wire

// ==== common/paLaneIf.sv ====
`default_nettype none

////////////////////////////////////////////////////////////
// decoder to register file, one per lane
////////////////////////////////////////////////////////////
interface decodedOpIf;
	logic valid;
	paIsaPkg::opcodeT opcode;
	paIsaPkg::formatT format;
	// source and destination register
	paCoreCfgPkg::regAddrT primReg;
	// immediate or register index
	paCoreCfgPkg::dataT secOperand;

	modport source (output valid, output opcode, output format, output primReg,
		output secOperand);
	modport sink (input valid, input opcode, input format, input primReg,
		input secOperand);
endinterface

////////////////////////////////////////////////////////////
// register file to arithmetic unit, one per lane
////////////////////////////////////////////////////////////
interface issueOpIf;
	logic valid;
	paIsaPkg::opcodeT opcode;
	// destination of the result
	paCoreCfgPkg::regAddrT primReg;
	paCoreCfgPkg::dataT primValue;
	paCoreCfgPkg::dataT secValue;

	modport source (output valid, output opcode, output primReg, output primValue,
		output secValue);
	modport sink (input valid, input opcode, input primReg, input primValue,
		input secValue);
endinterface

`default_nettype wire

// ==== common/paIsaPkg.sv ====
`default_nettype none

package paIsaPkg;

	// arithmetic opcodes, other values behave as nop
	typedef enum logic [6:0] {
		nop   = 7'd0,
		add   = 7'd1,
		sub   = 7'd2,
		andOp = 7'd3,
		orOp  = 7'd4,
		xorOp = 7'd5,
		mov   = 7'd6
	} opcodeT;

	// secondary operand kind
	typedef enum logic {
		regReg = 1'b0,
		regImm = 1'b1
	} formatT;

	// instruction field positions
	localparam int opcodeHi = 31;
	localparam int opcodeLo = 25;
	localparam int formatPos = 24;
	localparam int primRegHi = 20;
	localparam int primRegLo = 16;
	// regReg form only uses the low 5 bits as register index
	localparam int secOperandHi = 15;
	localparam int secOperandLo = 0;

endpackage

`default_nettype wire

// ==== common/paCoreCfgPkg.sv ====
`default_nettype none

package paCoreCfgPkg;

	// register and operand value
	typedef logic [15:0] dataT;

	// register index, 32 registers
	typedef logic [4:0] regAddrT;

	// one byte from the loader
	typedef logic [7:0] byteT;

	// one lane's instruction
	typedef logic [31:0] instrT;

	// one bundle, lane A in the upper half, lane B in the lower half
	typedef logic [63:0] bundleT;

	// bundle address
	typedef logic [15:0] pcT;

	// default bundle memory depth
	localparam int defaultBundleDepth = 64;

endpackage

`default_nettype wire
